// ==== design/conv_num_pkg.sv ====
/* Numeric types of the expand datapath
   Data word, widths and the two views of the biased accumulator */
package conv_num_pkg;

	// Pixel and weight word
	localparam int DATA_W = 16;

	// Biased accumulator word
	localparam int ACC_W = 32;

	// Rescale field layout inside the accumulator
	localparam int FRAC_W = 14;
	localparam int MAG_W = DATA_W - 1;
	localparam int GUARD_W = ACC_W - 1 - MAG_W - FRAC_W;

	typedef logic signed [DATA_W-1:0] data_t;

	// Biased sum as one signed value, or split for the rescale
	// sign | guard | mag (bits 28..14) | frac
	typedef union packed {
		logic signed [ACC_W-1:0] sum;
		struct packed {
			logic               sign;
			logic [GUARD_W-1:0] guard;
			logic [MAG_W-1:0]   mag;
			logic [FRAC_W-1:0]  frac;
		} fld;
	} acc_word_u;

endpackage

// ==== design/layer_cfg_pkg.sv ====
/* Layer identifiers and default layer geometry */
package layer_cfg_pkg;

	// Which expand layer drives the shared MAC array
	typedef enum logic {
		LAYER_FIRE4 = 1'b0,
		LAYER_FIRE5 = 1'b1
	} layer_id_t;

	////////////////////
	// Default geometry
	////////////////////

	// Input channels per pixel
	localparam int DEF_CHIN = 8;

	// Output channels per pixel
	localparam int DEF_CHOUT = 4;

	// Output side of WOUT x WOUT pixels per layer
	localparam int DEF_WOUT = 4;

endpackage

// ==== design/mac_unit.sv ====
`timescale 1ns/1ns
/* Signed multiply-accumulate cell with synchronous clear */
module mac_unit
	import conv_num_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    clr,
	input  logic                    en,
	input  data_t                   pix,
	input  data_t                   ker,
	output logic signed [ACC_W-1:0] acc
);

	logic signed [ACC_W-1:0] prod;

	// Full width signed product
	assign prod = pix * ker;

	// First channel of a pixel overwrites the old sum
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc <= '0;
		end else if (en) begin
			if (clr) begin
				acc <= prod;
			end else begin
				acc <= acc + prod;
			end
		end
	end

endmodule

// ==== design/layer_param_rom.sv ====
`timescale 1ns/1ns
/* Constant weight and bias tables of fire4 and fire5 */
module layer_param_rom
	import conv_num_pkg::*;
	import layer_cfg_pkg::*;
#(
	parameter int CHIN  = 8,
	parameter int CHOUT = 4
) (
	input  layer_id_t               layer_sel,
	input  logic [$clog2(CHIN)-1:0] ch_addr,
	output data_t                   w_vec [CHOUT],
	output logic signed [ACC_W-1:0] b_vec [CHOUT]
);

	// Eight base weights per layer
	function automatic data_t weight_of(input layer_id_t l, input logic [2:0] k);
		data_t w;
		case ({l, k})
			4'h0: w = 16'sd1200;
			4'h1: w = -16'sd850;
			4'h2: w = 16'sd2047;
			4'h3: w = -16'sd300;
			4'h4: w = 16'sd640;
			4'h5: w = -16'sd1500;
			4'h6: w = 16'sd910;
			4'h7: w = 16'sd75;
			4'h8: w = -16'sd700;
			4'h9: w = 16'sd1800;
			4'ha: w = 16'sd430;
			4'hb: w = -16'sd2200;
			4'hc: w = 16'sd1333;
			4'hd: w = 16'sd260;
			4'he: w = -16'sd95;
			4'hf: w = 16'sd1024;
		endcase
		return w;
	endfunction

	// Per output channel bias, four per layer
	function automatic logic signed [ACC_W-1:0] bias_of(input layer_id_t l, input logic [1:0] k);
		logic signed [ACC_W-1:0] b;
		case ({l, k})
			3'd0: b = 32'sd1200000;
			3'd1: b = -32'sd3000000;
			3'd2: b = 32'sd450000;
			3'd3: b = -32'sd50000;
			3'd4: b = 32'sd2000000;
			3'd5: b = -32'sd800000;
			3'd6: b = 32'sd0;
			3'd7: b = 32'sd6000000;
		endcase
		return b;
	endfunction

	// Each output channel walks the weight table at its own offset
	always_comb begin
		for (int oc = 0; oc < CHOUT; oc++) begin
			w_vec[oc] = weight_of(layer_sel, 3'((int'(ch_addr) + 3 * oc) % 8));
			b_vec[oc] = bias_of(layer_sel, 2'(oc % 4));
		end
	end

	always_comb begin
		a_ch_range: assert (int'(ch_addr) < CHIN)
			else $error("ch_addr %0d out of range", ch_addr);
	end

endmodule

// ==== design/expand1x1_engine.sv ====
`timescale 1ns/1ns
/* 1x1 expand engine with input sequencing, MAC array, bias, ReLU and rescale
   Layer end and finish flags with write-done feedback */
module expand1x1_engine
	import conv_num_pkg::*;
	import layer_cfg_pkg::*;
#(
	parameter int CHIN  = 8,
	parameter int CHOUT = 4,
	parameter int WOUT  = 4
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 fire4_en,
	input  logic                                 fire5_en,
	output logic [$clog2(WOUT*WOUT*CHIN)-1:0]    ifm_addr,
	input  data_t                                ifm_data,
	output layer_id_t                            layer_sel,
	output logic [$clog2(CHIN)-1:0]              ch_addr,
	input  data_t                                w_vec [CHOUT],
	input  logic signed [ACC_W-1:0]              b_vec [CHOUT],
	output logic                                 ofm_valid,
	output data_t                                ofm_vec [CHOUT],
	output logic [$clog2(WOUT*WOUT)-1:0]         pix_idx,
	input  logic                                 layer_written,
	output logic                                 fire4_finish,
	output logic                                 fire5_finish
);

	localparam int NPIX = WOUT * WOUT;
	localparam int IAW = $clog2(NPIX * CHIN);
	localparam int CAW = $clog2(CHIN);
	localparam int PXW = $clog2(NPIX);

	layer_id_t layer_q;
	logic [$clog2(CHIN+1)-1:0] ch_cnt;
	logic [$clog2(NPIX+1)-1:0] pix_cnt;
	logic end4;
	logic end5;
	logic wr4_q;
	logic wr5_q;
	logic cur_end;
	logic run;
	logic issue;
	logic iss_v;
	logic iss_clr;
	logic iss_last;
	logic sum_v;
	logic [PXW-1:0] iss_pix;
	data_t w_q [CHOUT];
	logic signed [ACC_W-1:0] acc [CHOUT];
	acc_word_u biased [CHOUT];
	data_t res [CHOUT];

	// Hold the last layer while both enables are low
	always_comb begin
		if (fire5_en)
			layer_sel = LAYER_FIRE5;
		else if (fire4_en)
			layer_sel = LAYER_FIRE4;
		else
			layer_sel = layer_q;
	end

	////////////////////
	// Input sequencing
	////////////////////

	// ch_cnt == CHIN is the clear slot between pixels
	assign cur_end = (layer_sel == LAYER_FIRE5) ? end5 : end4;
	assign run = (fire4_en || fire5_en) && !cur_end && (pix_cnt != NPIX);
	assign issue = run && (ch_cnt != CHIN);
	assign ch_addr = issue ? ch_cnt[CAW-1:0] : '0;
	assign ifm_addr = issue ? IAW'(pix_cnt * CHIN) + IAW'(ch_addr) : '0;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ch_cnt <= '0;
			pix_cnt <= '0;
			layer_q <= LAYER_FIRE4;
		end else begin
			layer_q <= layer_sel;
			if (layer_written) begin
				ch_cnt <= '0;
				pix_cnt <= '0;
			end else if (run) begin
				if (ch_cnt == CHIN) begin
					ch_cnt <= '0;
				end else begin
					ch_cnt <= ch_cnt + 1'b1;
				end
				if (ch_cnt == CHIN - 1)
					pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	// Pipeline valids trail each address by the one cycle read latency
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			iss_v <= 1'b0;
			iss_clr <= 1'b0;
			iss_last <= 1'b0;
			sum_v <= 1'b0;
			ofm_valid <= 1'b0;
		end else begin
			iss_v <= issue;
			iss_clr <= issue && (ch_cnt == 0);
			iss_last <= issue && (ch_cnt == CHIN - 1);
			sum_v <= iss_last;
			ofm_valid <= sum_v;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			w_q <= w_vec;
			iss_pix <= PXW'(pix_cnt);
		end
		if (sum_v) begin
			ofm_vec <= res;
			pix_idx <= iss_pix;
		end
	end

	////////////////////
	// MAC array
	////////////////////

	for (genvar i = 0; i < CHOUT; i++) begin : g_mac
		mac_unit u_mac (
			.clk (clk),
			.rst (rst),
			.clr (iss_clr),
			.en  (iss_v),
			.pix (ifm_data),
			.ker (w_q[i]),
			.acc (acc[i])
		);
	end

	// Bias, then ReLU and keep bits 28..14
	always_comb begin
		for (int i = 0; i < CHOUT; i++) begin
			biased[i].sum = acc[i] + b_vec[i];
			if (biased[i].sum < 0)
				res[i] = '0;
			else
				res[i] = {1'b0, biased[i].fld.mag};
		end
	end

	////////////////////
	// Layer end and finish
	////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			end4 <= 1'b0;
			end5 <= 1'b0;
			wr4_q <= 1'b0;
			wr5_q <= 1'b0;
		end else begin
			if (ofm_valid && (pix_idx == PXW'(NPIX - 1))) begin
				if (layer_sel == LAYER_FIRE5)
					end5 <= 1'b1;
				else
					end4 <= 1'b1;
			end
			if (layer_written) begin
				if (layer_sel == LAYER_FIRE5)
					wr5_q <= 1'b1;
				else
					wr4_q <= 1'b1;
			end
		end
	end

	assign fire4_finish = end4 && !wr4_q;
	assign fire5_finish = end5 && !wr5_q;

	a_one_layer: assert property (@(posedge clk) disable iff (!rst) !(fire4_en && fire5_en))
		else $error("fire4_en and fire5_en high together");

	a_no_out_at_finish: assert property (@(posedge clk) disable iff (!rst)
		$rose(ofm_valid) |-> !(fire4_finish || fire5_finish))
		else $error("ofm_valid rose while a finish flag is high");

endmodule

// ==== design/ofm_ram_writer.sv ====
`timescale 1ns/1ns
/* Output memory writer with one word per cycle and a layer write-done pulse */
module ofm_ram_writer
	import conv_num_pkg::*;
	import layer_cfg_pkg::*;
#(
	parameter int CHOUT = 4,
	parameter int WOUT  = 4
) (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    ofm_valid,
	input  data_t                                   ofm_vec [CHOUT],
	input  logic [$clog2(WOUT*WOUT)-1:0]            pix_idx,
	input  layer_id_t                               layer_sel,
	output logic                                    ofm_we,
	output logic [$clog2(2*WOUT*WOUT*CHOUT)-1:0]    ofm_addr,
	output data_t                                   ofm_wdata,
	output logic                                    layer_written
);

	localparam int NPIX = WOUT * WOUT;
	localparam int OAW = $clog2(2 * NPIX * CHOUT);
	localparam int WCW = $clog2(CHOUT);

	data_t vec_q [CHOUT];
	logic [OAW-1:0] base_q;
	logic [WCW-1:0] wcnt;
	logic busy;
	logic last_pix;
	logic word_last;

	assign word_last = (wcnt == WCW'(CHOUT - 1));
	assign ofm_we = busy;
	assign ofm_addr = base_q + OAW'(wcnt);
	assign ofm_wdata = vec_q[wcnt];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			wcnt <= '0;
			last_pix <= 1'b0;
			layer_written <= 1'b0;
		end else begin
			layer_written <= busy && word_last && last_pix;
			if (ofm_valid) begin
				busy <= 1'b1;
				wcnt <= '0;
				last_pix <= (int'(pix_idx) == NPIX - 1);
			end else if (busy) begin
				if (word_last) begin
					busy <= 1'b0;
					wcnt <= '0;
				end else begin
					wcnt <= wcnt + 1'b1;
				end
			end
		end
	end

	// fire5 sits above the whole fire4 block
	always_ff @(posedge clk) begin
		if (ofm_valid) begin
			vec_q <= ofm_vec;
			base_q <= OAW'(int'(pix_idx) * CHOUT
				+ ((layer_sel == LAYER_FIRE5) ? NPIX * CHOUT : 0));
		end
	end

	a_no_overrun: assert property (@(posedge clk) disable iff (!rst)
		ofm_valid |-> (!busy || word_last))
		else $error("ofm_valid while vector still being written");

endmodule

// ==== design/fire_expand_top.sv ====
`timescale 1ns/1ns
/* Top level with engine, parameter ROM and output writer */
module fire_expand_top
	import conv_num_pkg::*;
	import layer_cfg_pkg::*;
#(
	parameter int CHIN  = DEF_CHIN,
	parameter int CHOUT = DEF_CHOUT,
	parameter int WOUT  = DEF_WOUT
) (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    fire4_en,
	input  logic                                    fire5_en,
	output logic [$clog2(WOUT*WOUT*CHIN)-1:0]       ifm_addr,
	input  data_t                                   ifm_data,
	output logic                                    ofm_we,
	output logic [$clog2(2*WOUT*WOUT*CHOUT)-1:0]    ofm_addr,
	output data_t                                   ofm_wdata,
	output logic                                    fire4_finish,
	output logic                                    fire5_finish
);

	layer_id_t layer_sel;
	logic [$clog2(CHIN)-1:0] ch_addr;
	data_t w_vec [CHOUT];
	logic signed [ACC_W-1:0] b_vec [CHOUT];
	logic ofm_valid;
	data_t ofm_vec [CHOUT];
	logic [$clog2(WOUT*WOUT)-1:0] pix_idx;
	logic layer_written;

	expand1x1_engine #(
		.CHIN  (CHIN),
		.CHOUT (CHOUT),
		.WOUT  (WOUT)
	) u_engine (
		.clk           (clk),
		.rst           (rst),
		.fire4_en      (fire4_en),
		.fire5_en      (fire5_en),
		.ifm_addr      (ifm_addr),
		.ifm_data      (ifm_data),
		.layer_sel     (layer_sel),
		.ch_addr       (ch_addr),
		.w_vec         (w_vec),
		.b_vec         (b_vec),
		.ofm_valid     (ofm_valid),
		.ofm_vec       (ofm_vec),
		.pix_idx       (pix_idx),
		.layer_written (layer_written),
		.fire4_finish  (fire4_finish),
		.fire5_finish  (fire5_finish)
	);

	layer_param_rom #(
		.CHIN  (CHIN),
		.CHOUT (CHOUT)
	) u_rom (
		.layer_sel (layer_sel),
		.ch_addr   (ch_addr),
		.w_vec     (w_vec),
		.b_vec     (b_vec)
	);

	ofm_ram_writer #(
		.CHOUT (CHOUT),
		.WOUT  (WOUT)
	) u_writer (
		.clk           (clk),
		.rst           (rst),
		.ofm_valid     (ofm_valid),
		.ofm_vec       (ofm_vec),
		.pix_idx       (pix_idx),
		.layer_sel     (layer_sel),
		.ofm_we        (ofm_we),
		.ofm_addr      (ofm_addr),
		.ofm_wdata     (ofm_wdata),
		.layer_written (layer_written)
	);

	// Writer drains a vector within one pixel period
	a_writer_rate: assert property (@(posedge clk) disable iff (!rst) CHOUT <= CHIN + 1)
		else $error("CHOUT %0d exceeds CHIN+1 %0d", CHOUT, CHIN + 1);

endmodule

// ==== verif/expand_checker.sv ====
`timescale 1ns/1ns
/* Output memory and finish flag checker for the expand engine */
module expand_checker
	import conv_num_pkg::*;
#(
	parameter int CHOUT = 4,
	parameter int NPIX  = 16,
	parameter int OAW   = 7
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           ofm_we,
	input  logic [OAW-1:0] ofm_addr,
	input  data_t          ofm_wdata,
	input  logic           fire4_finish,
	input  logic           fire5_finish,
	input  logic [15:0]    exp_mem [2*NPIX*CHOUT],
	input  logic           run_done,
	output int             data_errs,
	output int             flow_errs
);

	localparam int LWORDS = NPIX * CHOUT;

	int hits [2*LWORDS];
	int wr_cnt [2];
	bit rose [2];
	bit fell [2];
	logic f4_q = 1'b0;
	logic f5_q = 1'b0;
	logic done_q = 1'b0;

	initial begin
		data_errs = 0;
		flow_errs = 0;
		foreach (hits[i])
			hits[i] = 0;
		wr_cnt = '{0, 0};
	end

	// Edge tracking of one finish flag
	task automatic track_finish(input int l, input logic cur, input logic prev);
		if (cur && !prev) begin
			if (fell[l]) begin
				$display("Finish flag of layer %0d rose a second time at %0t", l, $time);
				flow_errs++;
			end
			if (wr_cnt[l] < LWORDS - CHOUT) begin
				$display("Finish flag of layer %0d rose after only %0d writes", l, wr_cnt[l]);
				flow_errs++;
			end
			rose[l] = 1'b1;
		end
		if (!cur && prev) begin
			if (wr_cnt[l] != LWORDS) begin
				$display("Finish flag of layer %0d fell with %0d writes stored", l, wr_cnt[l]);
				flow_errs++;
			end
			fell[l] = 1'b1;
		end
	endtask

	always @(posedge clk) begin
		int a;
		int l;
		if (!rst) begin
			if (fire4_finish || fire5_finish || ofm_we) begin
				$display("Output active during reset at %0t", $time);
				flow_errs++;
			end
		end else begin
			if (ofm_we) begin
				a = int'(ofm_addr);
				l = (a >= LWORDS) ? 1 : 0;
				if (hits[a] != 0) begin
					$display("Address %0d written again at %0t", a, $time);
					flow_errs++;
				end
				hits[a]++;
				wr_cnt[l]++;
				if (ofm_wdata !== data_t'(exp_mem[a])) begin
					$display("[ERROR] %0t ofm_wdata at addr %0d: got %0d expected %0d",
						$time, a, ofm_wdata, exp_mem[a]);
					data_errs++;
				end
			end
			track_finish(0, fire4_finish, f4_q);
			track_finish(1, fire5_finish, f5_q);
		end
		f4_q <= fire4_finish;
		f5_q <= fire5_finish;

		////////////////////
		// End of run coverage
		////////////////////
		if (run_done && !done_q) begin
			foreach (hits[i]) begin
				if (hits[i] != 1) begin
					$display("Address %0d written %0d times", i, hits[i]);
					flow_errs++;
				end
			end
			for (int k = 0; k < 2; k++) begin
				if (!rose[k] || !fell[k]) begin
					$display("Finish flag of layer %0d never completed a pulse", k);
					flow_errs++;
				end
			end
		end
		done_q <= run_done;
	end

endmodule

// ==== verif/tb_fire_expand.sv ====
`timescale 1ns/1ns
/* Testbench for the fire expand top with clock, reset, feature memory model,
   layer sequencing with an enable stall, watchdog and final report */
module tb_fire_expand
	import conv_num_pkg::*;
;

	localparam int CHIN = 8;
	localparam int CHOUT = 4;
	localparam int WOUT = 4;
	localparam int NPIX = WOUT * WOUT;
	localparam int IWORDS = NPIX * CHIN;
	localparam int OWORDS = NPIX * CHOUT;
	localparam int RST_CYC = 10;
	localparam int MAX_GAP = 20;
	localparam int STALL_AT = 40;
	localparam int LIMIT = 2 * NPIX * (CHIN + 1 + CHOUT) + RST_CYC + 2 * MAX_GAP + 64;

	logic clk = 1'b0;
	logic rst;
	logic fire4_en;
	logic fire5_en;
	logic [$clog2(IWORDS)-1:0] ifm_addr;
	data_t ifm_data;
	logic ofm_we;
	logic [$clog2(2*OWORDS)-1:0] ofm_addr;
	data_t ofm_wdata;
	logic fire4_finish;
	logic fire5_finish;
	logic run_done;
	logic cur_layer;
	int data_errs;
	int flow_errs;
	int stim_errs = 0;
	data_t ifm_mem [2*IWORDS];
	logic [15:0] exp_mem [2*OWORDS];

	always #4 clk = ~clk;

	fire_expand_top #(
		.CHIN  (CHIN),
		.CHOUT (CHOUT),
		.WOUT  (WOUT)
	) u_dut (
		.clk          (clk),
		.rst          (rst),
		.fire4_en     (fire4_en),
		.fire5_en     (fire5_en),
		.ifm_addr     (ifm_addr),
		.ifm_data     (ifm_data),
		.ofm_we       (ofm_we),
		.ofm_addr     (ofm_addr),
		.ofm_wdata    (ofm_wdata),
		.fire4_finish (fire4_finish),
		.fire5_finish (fire5_finish)
	);

	expand_checker #(
		.CHOUT (CHOUT),
		.NPIX  (NPIX),
		.OAW   ($clog2(2*OWORDS))
	) u_chk (
		.clk          (clk),
		.rst          (rst),
		.ofm_we       (ofm_we),
		.ofm_addr     (ofm_addr),
		.ofm_wdata    (ofm_wdata),
		.fire4_finish (fire4_finish),
		.fire5_finish (fire5_finish),
		.exp_mem      (exp_mem),
		.run_done     (run_done),
		.data_errs    (data_errs),
		.flow_errs    (flow_errs)
	);

	// Feature memory with one cycle read latency
	always @(posedge clk)
		ifm_data <= ifm_mem[int'(cur_layer) * IWORDS + int'(ifm_addr)];

	// Each pixel line holds layer, pixel, CHIN inputs and CHOUT expected words
	task automatic load_cases();
		int fd;
		int r;
		int l;
		int p;
		int v;
		string hdr;
		fd = $fopen("verif/expand_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verif/expand_cases.txt");
			stim_errs++;
		end else begin
			r = $fgets(hdr, fd);
			r = $fgets(hdr, fd);
			for (int n = 0; n < 2 * NPIX; n++) begin
				r = $fscanf(fd, "%d %d", l, p);
				if (r != 2 || l < 0 || l > 1 || p < 0 || p >= NPIX) begin
					$display("Malformed pixel line %0d in cases file", n);
					stim_errs++;
					break;
				end
				for (int c = 0; c < CHIN; c++) begin
					r = $fscanf(fd, "%d", v);
					ifm_mem[l * IWORDS + p * CHIN + c] = data_t'(v);
				end
				for (int k = 0; k < CHOUT; k++) begin
					r = $fscanf(fd, "%d", v);
					exp_mem[l * OWORDS + p * CHOUT + k] = 16'(v);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic set_enable(input logic l, input logic v);
		if (l)
			fire5_en <= v;
		else
			fire4_en <= v;
	endtask

	// Enable held for one layer until its finish pulse is over
	task automatic run_layer(input logic l, input bit stall);
		int gap;
		@(posedge clk);
		cur_layer <= l;
		set_enable(l, 1'b1);
		if (stall) begin
			repeat (STALL_AT) @(posedge clk);
			gap = int'($urandom_range(MAX_GAP, 1));
			set_enable(l, 1'b0);
			repeat (gap) @(posedge clk);
			set_enable(l, 1'b1);
		end
		while (!(l ? fire5_finish : fire4_finish))
			@(posedge clk);
		while (l ? fire5_finish : fire4_finish)
			@(posedge clk);
		set_enable(l, 1'b0);
	endtask

	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("Timeout: layers not finished after %0d cycles", LIMIT);
		$display("errors: data %0d, protocol %0d, stimulus %0d",
			data_errs, flow_errs, stim_errs);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int gap;
		void'($urandom(32'h6d6b));
		rst = 1'b0;
		fire4_en = 1'b0;
		fire5_en = 1'b0;
		ifm_data = '0;
		run_done = 1'b0;
		cur_layer = 1'b0;
		load_cases();
		repeat (RST_CYC) @(posedge clk);
		rst <= 1'b1;
		run_layer(1'b0, 1'b1);
		gap = int'($urandom_range(MAX_GAP, 1));
		repeat (gap) @(posedge clk);
		run_layer(1'b1, 1'b0);
		repeat (4) @(posedge clk);
		run_done <= 1'b1;
		repeat (2) @(posedge clk);
		$display("errors: data %0d, protocol %0d, stimulus %0d",
			data_errs, flow_errs, stim_errs);
		if (data_errs + flow_errs + stim_errs == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
design/conv_num_pkg.sv
design/layer_cfg_pkg.sv
design/mac_unit.sv
design/layer_param_rom.sv
design/expand1x1_engine.sv
design/ofm_ram_writer.sv
design/fire_expand_top.sv
verif/expand_checker.sv
verif/tb_fire_expand.sv

// ==== Makefile ====
# Verilator build and run for the fire expand testbench

VERILATOR ?= verilator
TOP       ?= tb_fire_expand
FLIST     ?= files.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell cat $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST) verif/expand_cases.txt
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@grep -q "TEST PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/expand_cases.txt ====
# layer pixel  ifm ch0..ch7 (one pixel per line)  expected ofm oc0..oc3
# layer 0 is fire4, layer 1 is fire5, expected words are ReLU of bits 28..14
0 0 10000 0 0 0 0 0 0 0 805 0 582 0
0 1 0 -8000 0 0 0 0 0 0 488 0 0 0
0 2 0 0 12000 0 0 0 0 0 1572 0 906 0
0 3 0 0 0 -20000 0 0 0 0 439 0 1065 0
0 4 0 0 0 0 15000 0 0 0 659 0 1901 0
0 5 0 0 0 0 0 -6000 0 0 622 0 137 0
0 6 0 0 0 0 0 0 25000 0 1461 0 1004 111
0 7 0 0 0 0 0 0 0 30000 210 3565 0 2194
0 8 -5000 0 0 0 0 0 0 0 0 0 0 256
0 9 0 20000 0 0 0 0 0 0 0 598 119 2495
0 10 0 0 -3000 0 0 0 0 0 0 91 0 51
0 11 0 0 0 7000 0 0 0 0 0 205 0 270
0 12 0 0 0 0 -12000 0 0 0 0 0 0 1095
0 13 0 0 0 0 0 9000 0 0 0 476 0 496
0 14 0 0 0 0 0 0 -10000 0 0 335 0 0
0 15 0 0 0 0 0 0 0 32000 219 3814 0 2340
1 0 8000 0 0 0 0 0 0 0 0 0 0 1245
1 1 0 -4000 0 0 0 0 0 0 0 0 0 261
1 2 0 0 16000 0 0 0 0 0 541 205 0 0
1 3 0 0 0 -9000 0 0 0 0 1330 3 0 0
1 4 0 0 0 0 11000 0 0 0 1017 638 288 540
1 5 0 0 0 0 0 -14000 0 0 0 549 1879 447
1 6 0 0 0 0 0 0 20000 0 6 2148 1627 1616
1 7 0 0 0 0 0 0 0 -7000 0 0 0 665
1 8 -13000 0 0 0 0 0 0 0 677 1696 75 0
1 9 0 6000 0 0 0 0 0 0 781 439 375 523
1 10 0 0 -2000 0 0 0 0 0 69 0 85 634
1 11 0 0 0 5000 0 0 0 0 0 0 549 773
1 12 0 0 0 0 -18000 0 0 0 0 0 0 80
1 13 0 0 0 0 0 24000 0 0 502 0 0 227
1 14 0 0 0 0 0 0 -30000 0 296 0 0 0
1 15 0 0 0 0 0 0 0 13000 934 292 206 0
